/* source/pic_pkg.sv */
//################################################
// pic shared definitions
// widths, register map, vector table base,
// apb request/response structs, core write strobes
// and the arbiter state encoding
//################################################
package pic_pkg;

   //################################################
   // widths
   //################################################
   localparam int ADDR_W = 32;          // address and data width

   typedef logic [ADDR_W-1:0] word_t;   // apb data, iret, pc, vectors
   typedef logic [5:0]        reg_off_t; // register byte offset

   //################################################
   // register map
   //################################################
   localparam reg_off_t REG_IRET   = 6'h00; // interrupt return address
   localparam reg_off_t REG_IMASK  = 6'h04; // line mask, bit 0 ignored
   localparam reg_off_t REG_ILAT   = 6'h08; // latched lines, replace
   localparam reg_off_t REG_ILATST = 6'h0C; // latched lines, set
   localparam reg_off_t REG_ILATCL = 6'h10; // latched lines, clear
   localparam reg_off_t REG_IPEND  = 6'h14; // active levels

   // vector table, entries 4 bytes apart
   localparam word_t IVT_BASE = 32'h0000_0040;

   //################################################
   // bus structs
   //################################################
   // requester side
   typedef struct packed {
      logic     psel;
      logic     penable;
      logic     pwrite;
      reg_off_t paddr;
      word_t    pwdata;
   } apb_req_t;

   // completer side
   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

   // decoded writes into the core, one cycle each
   typedef struct packed {
      logic  wr_ilat;
      logic  wr_ilatst;
      logic  wr_ilatcl;
      logic  wr_ipend;
      word_t wdata;
   } pic_wr_t;

   // arbiter grant tracking
   typedef enum logic {
      ARB_IDLE,
      ARB_ACCESS
   } arb_state_t;

endpackage

/* source/apb_arbiter.sv */
//################################################
// apb arbiter
// merges host and core requesters onto one bus,
// round robin on collisions, losing side is held
// off by pready low until its own turn
//################################################
module apb_arbiter
   import pic_pkg::*;
(
   input  logic     clk,
   input  logic     nreset,
   input  apb_req_t host_req,
   output apb_rsp_t host_rsp,
   input  apb_req_t core_req,
   output apb_rsp_t core_rsp,
   output apb_req_t bus_req,
   input  apb_rsp_t bus_rsp
);

   arb_state_t state;
   logic       gnt_core_q;  // grant held through the access phase
   logic       prefer_core; // round robin pointer, host first
   logic       pick_core;   // idle-time choice
   logic       gnt_core;    // effective grant this cycle
   logic       xfer_done;   // completing access cycle on the bus
   apb_req_t   sel_req;

   //################################################
   // grant selection
   //################################################
   // core wins only if host is quiet or it's core's turn
   assign pick_core = core_req.psel & (~host_req.psel | prefer_core);
   assign gnt_core  = (state == ARB_ACCESS) ? gnt_core_q : pick_core;

   assign sel_req = gnt_core ? core_req : host_req;

   // idle phase is always a setup cycle on the bus
   always_comb
   begin
      bus_req = sel_req;
      if (state == ARB_IDLE)
         bus_req.penable = 1'b0; // a waiting loser restarts with setup
   end

   assign xfer_done = bus_req.psel & bus_req.penable & bus_rsp.pready;

   //################################################
   // grant state
   //################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state       <= ARB_IDLE;
         gnt_core_q  <= 1'b0;
         prefer_core <= 1'b0;
      end
      else
      begin
         case (state)
            ARB_IDLE:
            begin
               if (host_req.psel | core_req.psel)
               begin
                  state      <= ARB_ACCESS;
                  gnt_core_q <= pick_core; // lock grant for access
               end
            end
            ARB_ACCESS:
            begin
               if (xfer_done)
               begin
                  state       <= ARB_IDLE;
                  prefer_core <= ~gnt_core_q; // other side next time
               end
            end
            default: state <= ARB_IDLE;
         endcase
      end
   end

   //################################################
   // response routing
   //################################################
   // only the granted side in access sees the completer
   always_comb
   begin
      host_rsp = '0;
      core_rsp = '0;
      if (state == ARB_ACCESS)
      begin
         if (gnt_core_q)
            core_rsp = bus_rsp;
         else
            host_rsp = bus_rsp;
      end
   end

endmodule

/* source/pic_regs.sv */
//################################################
// pic register bank
// apb completer, no wait states
// decodes write strobes for the core, holds imask
// and iret, muxes read data zero extended
//################################################
module pic_regs
   import pic_pkg::*;
#(
   parameter int NUM_IRQ = 10
)
(
   input  logic               clk,
   input  logic               nreset,
   input  apb_req_t           bus_req,
   output apb_rsp_t           bus_rsp,
   output pic_wr_t            pic_wr,
   output logic [NUM_IRQ-1:0] imask,
   output word_t              iret,
   input  logic [NUM_IRQ-1:0] ilat,
   input  logic [NUM_IRQ-1:0] ipend,
   input  logic               flush,
   input  word_t              pc_next
);

   logic  access;   // completing access cycle
   logic  wr_en;
   logic  rd_en;
   logic  mapped;   // offset hits the register map
   logic  wr_imask;
   logic  wr_iret;
   word_t rdata;

   //################################################
   // access decode
   //################################################
   // pready is tied high, so every access cycle completes
   assign access = bus_req.psel & bus_req.penable;
   assign wr_en  = access & bus_req.pwrite & mapped;
   assign rd_en  = access & ~bus_req.pwrite & mapped;

   // write strobes, local and toward the core
   always_comb
   begin
      pic_wr       = '0;
      pic_wr.wdata = bus_req.pwdata;
      wr_imask     = 1'b0;
      wr_iret      = 1'b0;
      if (wr_en)
      begin
         case (bus_req.paddr)
            REG_IRET:   wr_iret          = 1'b1;
            REG_IMASK:  wr_imask         = 1'b1;
            REG_ILAT:   pic_wr.wr_ilat   = 1'b1;
            REG_ILATST: pic_wr.wr_ilatst = 1'b1;
            REG_ILATCL: pic_wr.wr_ilatcl = 1'b1;
            REG_IPEND:  pic_wr.wr_ipend  = 1'b1;
            default:    wr_iret          = 1'b0;
         endcase
      end
   end

   //################################################
   // read mux
   //################################################
   always_comb
   begin
      rdata  = '0;
      mapped = 1'b1;
      case (bus_req.paddr)
         REG_IRET:   rdata                = iret;
         REG_IMASK:  rdata[NUM_IRQ-1:0]   = imask;
         REG_ILAT,
         REG_ILATST,
         REG_ILATCL: rdata[NUM_IRQ-1:0]   = ilat; // set/clear alias read ilat
         REG_IPEND:  rdata[NUM_IRQ-1:0]   = ipend;
         default:    mapped               = 1'b0; // hole in the map
      endcase
   end

   assign bus_rsp.prdata  = rd_en ? rdata : '0;
   assign bus_rsp.pready  = 1'b1;               // no wait states
   assign bus_rsp.pslverr = access & ~mapped;   // unmapped offset

   //################################################
   // imask / iret
   //################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         imask <= '0;
      else if (wr_imask)
         imask <= bus_req.pwdata[NUM_IRQ-1:0];
   end

   // entry capture of the next pc beats a register write
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         iret <= '0;
      else if (flush)
         iret <= pc_next;
      else if (wr_iret)
         iret <= bus_req.pwdata;
   end

endmodule

/* source/pic_core.sv */
//################################################
// pic interrupt core
// rising edge detect into ilat, lowest index wins
// against imask and ipend, entry register drives
// irq and the vector, flush straight from select
//################################################
module pic_core
   import pic_pkg::*;
#(
   parameter int NUM_IRQ = 10
)
(
   input  logic               clk,
   input  logic               nreset,
   input  logic [NUM_IRQ-1:0] ext_irq,
   input  pic_wr_t            pic_wr,
   input  logic [NUM_IRQ-1:0] imask,
   input  logic               irq_en,
   input  logic               ic_wait,
   input  logic               rti,
   output logic [NUM_IRQ-1:0] ilat,
   output logic [NUM_IRQ-1:0] ipend,
   output logic               flush,
   output logic               irq,
   output word_t              irq_addr
);

   logic [NUM_IRQ-1:0] irq_shadow;  // last sample of ext_irq
   logic [NUM_IRQ-1:0] irq_event;   // 0 to 1 change this edge
   logic [NUM_IRQ-1:0] masked_ilat;
   logic [NUM_IRQ-1:0] select;      // one hot or zero
   logic [NUM_IRQ-1:0] take;        // select accepted by the pipeline
   logic [NUM_IRQ-1:0] entry;       // registered select
   logic [NUM_IRQ-1:0] wdata;
   logic [NUM_IRQ-1:0] ilat_nxt;
   logic [NUM_IRQ-1:0] ipend_nxt;
   logic [NUM_IRQ-1:0] ipend_rti;   // ipend minus its lowest set bit

   assign wdata = pic_wr.wdata[NUM_IRQ-1:0];

   //################################################
   // edge detect
   //################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         irq_shadow <= '0;
      else
         irq_shadow <= ext_irq;
   end

   assign irq_event = ext_irq & ~irq_shadow;

   //################################################
   // ilat
   //################################################
   // entry clears at the same edge the entry register loads
   assign take = select & {NUM_IRQ{~ic_wait}};

   always_comb
   begin
      ilat_nxt = ilat;
      if (pic_wr.wr_ilat)
         ilat_nxt = wdata;                // replace
      if (pic_wr.wr_ilatst)
         ilat_nxt = ilat_nxt | wdata;     // set
      if (pic_wr.wr_ilatcl)
         ilat_nxt = ilat_nxt & ~wdata;    // clear
      ilat_nxt = (ilat_nxt & ~take) | irq_event; // edges always win
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ilat <= '0;
      else
         ilat <= ilat_nxt;
   end

   //################################################
   // ipend
   //################################################
   // return drops the innermost level, i.e. lowest set bit
   assign ipend_rti = ipend & (ipend - NUM_IRQ'(1));

   always_comb
   begin
      if (pic_wr.wr_ipend)
         ipend_nxt = wdata;
      else if (rti)
         ipend_nxt = ipend_rti;
      else
         ipend_nxt = ipend;
      ipend_nxt = ipend_nxt | take;       // new level on entry
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ipend <= '0;
      else
         ipend <= ipend_nxt;
   end

   //################################################
   // priority
   //################################################
   // bit 0 cannot be masked
   assign masked_ilat = ilat & ~{imask[NUM_IRQ-1:1], 1'b0};

   always_comb
   begin : prio
      logic lower_lat;  // any unmasked request below i
      logic pend_at;    // any active level at or below i
      lower_lat = 1'b0;
      pend_at   = 1'b0;
      for (int i = 0; i < NUM_IRQ; i++)
      begin
         pend_at   = pend_at | ipend[i];
         select[i] = masked_ilat[i] & ~lower_lat & ~pend_at & irq_en;
         lower_lat = lower_lat | masked_ilat[i];
      end
   end

   assign flush = |select; // one cycle unless stalled

   //################################################
   // entry and vector
   //################################################
   // holds while the sequencer is not ready
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         entry <= '0;
      else if (!ic_wait)
         entry <= select;
   end

   assign irq = |entry;

   // one hot or-mux of table entries, zero when idle
   always_comb
   begin
      irq_addr = '0;
      for (int k = 0; k < NUM_IRQ; k++)
      begin
         if (entry[k])
            irq_addr = irq_addr | (IVT_BASE + (word_t'(k) << 2));
      end
   end

endmodule

/* source/pic_top.sv */
//################################################
// pic top level
// host and core apb ports share the register bank
// through the arbiter, core block faces the
// sequencer
//################################################
module pic_top
   import pic_pkg::*;
#(
   parameter int NUM_IRQ = 10          // interrupt lines, 2 to 32
)
(
   input  logic               clk,
   input  logic               nreset,
   // register access
   input  apb_req_t           host_req,
   output apb_rsp_t           host_rsp,
   input  apb_req_t           core_req,
   output apb_rsp_t           core_rsp,
   // pipeline
   input  logic [NUM_IRQ-1:0] ext_irq,
   input  word_t              pc_next,  // saved into iret on entry
   input  logic               irq_en,   // global enable
   input  logic               ic_wait,  // sequencer not ready
   input  logic               rti,      // return from interrupt
   output logic               irq,
   output word_t              irq_addr,
   output logic               flush
);

   apb_req_t           bus_req;  // arbitrated request
   apb_rsp_t           bus_rsp;
   pic_wr_t            pic_wr;   // decoded core writes
   logic [NUM_IRQ-1:0] imask;
   logic [NUM_IRQ-1:0] ilat;
   logic [NUM_IRQ-1:0] ipend;
   word_t              iret;     // return address, read back over apb

   //################################################
   // register path
   //################################################
   apb_arbiter apb_arbiter_i (
      .clk      (clk),
      .nreset   (nreset),
      .host_req (host_req),
      .host_rsp (host_rsp),
      .core_req (core_req),
      .core_rsp (core_rsp),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp)
   );

   pic_regs #(
      .NUM_IRQ (NUM_IRQ)
   ) pic_regs_i (
      .clk     (clk),
      .nreset  (nreset),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp),
      .pic_wr  (pic_wr),
      .imask   (imask),
      .iret    (iret),
      .ilat    (ilat),
      .ipend   (ipend),
      .flush   (flush),
      .pc_next (pc_next)
   );

   //################################################
   // interrupt path
   //################################################
   pic_core #(
      .NUM_IRQ (NUM_IRQ)
   ) pic_core_i (
      .clk      (clk),
      .nreset   (nreset),
      .ext_irq  (ext_irq),
      .pic_wr   (pic_wr),
      .imask    (imask),
      .irq_en   (irq_en),
      .ic_wait  (ic_wait),
      .rti      (rti),
      .ilat     (ilat),
      .ipend    (ipend),
      .flush    (flush),
      .irq      (irq),
      .irq_addr (irq_addr)
   );

endmodule

/* sim/pic_props.sv */
//################################################
// pic protocol and timing assertions
// bound into the top level, apb hold rules,
// pready routing, entry timing and single cycle irq
//################################################
module pic_props
   import pic_pkg::*;
(
   input logic     clk,
   input logic     nreset,
   input apb_req_t host_req,
   input apb_rsp_t host_rsp,
   input apb_req_t core_req,
   input apb_rsp_t core_rsp,
   input apb_req_t bus_req,
   input logic     irq_en,
   input logic     ic_wait,
   input logic     irq,
   input logic     flush
);

   int fail_cnt = 0; // failed assertions so far

   // granted setup goes to access with the same request
   assert property (@(posedge clk) disable iff (!nreset)
      (bus_req.psel && !bus_req.penable) |=> (bus_req.psel && bus_req.penable &&
      $stable({bus_req.pwrite, bus_req.paddr, bus_req.pwdata})))
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("bus request changed between setup and access");
   end

   // a held off requester keeps its access request
   assert property (@(posedge clk) disable iff (!nreset)
      (host_req.psel && host_req.penable && !host_rsp.pready) |=> $stable(host_req))
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("host request changed before pready");
   end

   assert property (@(posedge clk) disable iff (!nreset)
      (core_req.psel && core_req.penable && !core_rsp.pready) |=> $stable(core_req))
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("core request changed before pready");
   end

   // entry follows flush unless stalled
   assert property (@(posedge clk) disable iff (!nreset) (flush && !ic_wait) |=> irq)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("flush not followed by irq");
   end

   // no entry while interrupts are off
   assert property (@(posedge clk) disable iff (!nreset) (!irq_en && !ic_wait) |=> !irq)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("irq taken without irq_en");
   end

   assert property (@(posedge clk) disable iff (!nreset) (irq && !ic_wait) |=> !irq)
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("irq longer than one cycle");
   end

   // pready only to the side in its access phase, never both
   assert property (@(posedge clk) disable iff (!nreset)
      host_rsp.pready |-> (host_req.psel && host_req.penable && !core_rsp.pready))
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("host pready outside its own access phase");
   end

   assert property (@(posedge clk) disable iff (!nreset)
      core_rsp.pready |-> (core_req.psel && core_req.penable))
   else
   begin
      fail_cnt = fail_cnt + 1;
      $error("core pready outside its own access phase");
   end

endmodule

bind pic_top pic_props pic_props_i (
   .clk      (clk),
   .nreset   (nreset),
   .host_req (host_req),
   .host_rsp (host_rsp),
   .core_req (core_req),
   .core_rsp (core_rsp),
   .bus_req  (bus_req),
   .irq_en   (irq_en),
   .ic_wait  (ic_wait),
   .irq      (irq),
   .flush    (flush)
);

/* sim/tb_pic.sv */
//################################################
// pic testbench
// replays stimulus records against both apb ports
// and the pipeline inputs, keeps a reference model
// of ilat, ipend, imask and the round robin side
//################################################
module tb_pic
   import pic_pkg::*;
();

   localparam int NUM_IRQ = 10;

   // one line of the stimulus file
   typedef struct packed {
      logic [31:0] op;    // two letter opcode
      logic        port;  // 0 host, 1 core
      logic [31:0] arg;   // offset, line, mask or cycles
      word_t       d0;
      word_t       d1;
   } stim_rec_t;

   logic               clk;
   logic               nreset;
   apb_req_t           host_req;
   apb_rsp_t           host_rsp;
   apb_req_t           core_req;
   apb_rsp_t           core_rsp;
   logic [NUM_IRQ-1:0] ext_irq;
   word_t              pc_next;
   logic               irq_en;
   logic               ic_wait;
   logic               rti;
   logic               irq;
   word_t              irq_addr;
   logic               flush;

   stim_rec_t          recs[$];
   logic               done_q[$];    // apb completion order by port
   int                 cycle_cnt;
   int                 limit_cycles;
   logic [NUM_IRQ-1:0] m_ilat;       // reference model
   logic [NUM_IRQ-1:0] m_ipend;
   logic [NUM_IRQ-1:0] m_imask;
   logic               m_next_core;  // side that wins a collision

   pic_top #(
      .NUM_IRQ (NUM_IRQ)
   ) pic_top_i (
      .clk      (clk),
      .nreset   (nreset),
      .host_req (host_req),
      .host_rsp (host_rsp),
      .core_req (core_req),
      .core_rsp (core_rsp),
      .ext_irq  (ext_irq),
      .pc_next  (pc_next),
      .irq_en   (irq_en),
      .ic_wait  (ic_wait),
      .rti      (rti),
      .irq      (irq),
      .irq_addr (irq_addr),
      .flush    (flush)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // watchdog, also watches the bound assertions
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (pic_top_i.pic_props_i.fail_cnt != 0)
      begin
         $display("a bound assertion failed");
         abort_run();
      end
      else if (limit_cycles > 0 && cycle_cnt >= limit_cycles)
      begin
         $display("timeout, the run did not finish within %0d cycles", limit_cycles);
         abort_run();
      end
   end

   //################################################
   // checks
   //################################################
   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_irq_lines(input string name, input logic [NUM_IRQ-1:0] got,
                                  input logic [NUM_IRQ-1:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   //################################################
   // reference model
   //################################################
   task automatic apply_write(input reg_off_t off, input word_t data);
      case (off)
         REG_IMASK:  m_imask = data[NUM_IRQ-1:0];
         REG_ILAT:   m_ilat  = data[NUM_IRQ-1:0];             // replace
         REG_ILATST: m_ilat  = m_ilat | data[NUM_IRQ-1:0];
         REG_ILATCL: m_ilat  = m_ilat & ~data[NUM_IRQ-1:0];
         REG_IPEND:  m_ipend = data[NUM_IRQ-1:0];
         default:    ;                                       // iret not tracked
      endcase
   endtask

   function automatic logic [NUM_IRQ-1:0] model_read(input reg_off_t off);
      case (off)
         REG_IMASK: return m_imask;
         REG_ILAT:  return m_ilat;
         REG_IPEND: return m_ipend;
         default:   return '0;
      endcase
   endfunction

   //################################################
   // drivers
   //################################################
   // inputs change 1 unit after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic drive_req(input logic port, input apb_req_t req);
      if (port)
         core_req = req;
      else
         host_req = req;
   endtask

   // setup, then access until pready, sampled mid cycle
   task automatic apb_xfer(input logic port, input logic write, input reg_off_t off,
                           input word_t wdata, output word_t rdata, output logic err);
      apb_req_t req;
      apb_rsp_t rsp;
      logic     ready;
      req        = '0;
      req.psel   = 1'b1;
      req.pwrite = write;
      req.paddr  = off;
      req.pwdata = wdata;
      drive_req(port, req);
      next_cycle();
      req.penable = 1'b1;
      drive_req(port, req);
      ready = 1'b0;
      while (!ready)
      begin
         @(negedge clk);
         rsp   = port ? core_rsp : host_rsp;
         ready = rsp.pready;
         if (!ready)
            next_cycle();   // held off by the arbiter
      end
      rdata = rsp.prdata;
      err   = rsp.pslverr;
      if (write && !rsp.pslverr)
         apply_write(off, wdata);
      done_q.push_back(port);
      m_next_core = ~port;   // other side next time
      next_cycle();
      drive_req(port, '0);
   endtask

   task automatic pulse_lines(input logic [NUM_IRQ-1:0] mask);
      ext_irq = mask;
      next_cycle();          // edge sampled here
      ext_irq = '0;
      m_ilat  = m_ilat | mask;
   endtask

   // return drops the innermost level
   task automatic issue_rti();
      logic found;
      rti = 1'b1;
      next_cycle();
      rti   = 1'b0;
      found = 1'b0;
      for (int i = 0; i < NUM_IRQ; i++)
      begin
         if (m_ipend[i] && !found)
         begin
            m_ipend[i] = 1'b0;
            found      = 1'b1;
         end
      end
   endtask

   // flush this cycle, irq with the vector after the next edge
   task automatic expect_entry(input int k);
      word_t vec;
      vec = IVT_BASE + word_t'(k) * 4;
      @(negedge clk);
      check_bit("flush", flush, 1'b1);
      check_bit("irq", irq, 1'b0);
      next_cycle();
      @(negedge clk);
      check_bit("irq", irq, 1'b1);
      check_word("irq_addr", irq_addr, vec);
      check_bit("flush", flush, 1'b0);
      m_ilat[k]  = 1'b0;
      m_ipend[k] = 1'b1;
      next_cycle();
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         check_bit("irq", irq, 1'b0);
         next_cycle();
      end
   endtask

   // both ports write the same offset in the same cycle
   task automatic dual_write(input reg_off_t off, input word_t host_data,
                             input word_t core_data);
      logic  first_core;
      word_t host_rdata;
      word_t core_rdata;
      logic  host_err;
      logic  core_err;
      first_core = m_next_core;
      done_q.delete();
      fork
         apb_xfer(1'b0, 1'b1, off, host_data, host_rdata, host_err);
         apb_xfer(1'b1, 1'b1, off, core_data, core_rdata, core_err);
      join
      check_bit("first grant core", done_q[0], first_core);
      check_bit("host pslverr", host_err, 1'b0);
      check_bit("core pslverr", core_err, 1'b0);
   endtask

   //################################################
   // stimulus file
   //################################################
   task automatic load_stimulus();
      int               fd;
      int               n;
      logic [31:0]      op;
      logic [31:0]      f_port;
      logic [31:0]      f_arg;
      word_t            f_d0;
      word_t            f_d1;
      logic [8*128-1:0] skip;
      stim_rec_t        rec;
      fd = $fopen("sim/pic_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the stimulus file sim/pic_stimulus.txt");
         abort_run();
      end
      while (!$feof(fd))
      begin
         op = '0;
         n  = $fscanf(fd, "%s", op);
         if (n == 1 && op == "#")
            n = $fgets(skip, fd);   // column notes
         else if (n == 1)
         begin
            n = $fscanf(fd, "%h %h %h %h", f_port, f_arg, f_d0, f_d1);
            if (n != 4)
            begin
               $display("stimulus record %0d is incomplete", recs.size() + 1);
               abort_run();
            end
            rec.op   = op;
            rec.port = f_port[0];
            rec.arg  = f_arg;
            rec.d0   = f_d0;
            rec.d1   = f_d1;
            recs.push_back(rec);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_record(input stim_rec_t rec);
      word_t rdata;
      logic  err;
      case (rec.op)
         "wr":
         begin
            apb_xfer(rec.port, 1'b1, reg_off_t'(rec.arg), rec.d0, rdata, err);
            check_bit("pslverr", err, rec.d1[0]);
         end
         "rd":
         begin
            apb_xfer(rec.port, 1'b0, reg_off_t'(rec.arg), '0, rdata, err);
            check_bit("pslverr", err, rec.d1[0]);
            check_word("prdata", rdata, rec.d0);
         end
         "rm":   // expected lines from the model
         begin
            apb_xfer(rec.port, 1'b0, reg_off_t'(rec.arg), '0, rdata, err);
            check_bit("pslverr", err, 1'b0);
            check_irq_lines("prdata", rdata[NUM_IRQ-1:0], model_read(reg_off_t'(rec.arg)));
         end
         "pl": pulse_lines(rec.arg[NUM_IRQ-1:0]);
         "en": irq_en = rec.d0[0];
         "iw": ic_wait = rec.d0[0];
         "pc": pc_next = rec.d0;
         "rt": issue_rti();
         "xi": expect_entry(rec.arg);
         "ni": expect_quiet(rec.arg);
         "dw": dual_write(reg_off_t'(rec.arg), rec.d0, rec.d1);
         default:
         begin
            $display("unknown opcode in the stimulus file");
            abort_run();
         end
      endcase
   endtask

   //################################################
   // main sequence
   //################################################
   initial
   begin
      nreset       = 1'b0;
      host_req     = '0;
      core_req     = '0;
      ext_irq      = '0;
      pc_next      = '0;
      irq_en       = 1'b0;
      ic_wait      = 1'b0;
      rti          = 1'b0;
      m_ilat       = '0;
      m_ipend      = '0;
      m_imask      = '0;
      m_next_core  = 1'b0;   // host first after reset
      cycle_cnt    = 0;
      limit_cycles = 0;
      load_stimulus();
      limit_cycles = recs.size() * 20;
      repeat (4) @(posedge clk);
      #1;
      nreset = 1'b1;
      foreach (recs[i])
         run_record(recs[i]);
      if (pic_top_i.pic_props_i.fail_cnt == 0)
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
      else
      begin
         $display("a bound assertion failed near the end of the run");
         abort_run();
      end
   end

endmodule

/* sim/pic_stimulus.txt */
# columns op port arg d0 d1 in hex, port 0 is host and 1 is core
# arg is offset, pulse mask, line or cycles, d1 is pslverr or core data
wr 0 04 00000008 0
rd 1 04 00000008 0
wr 1 00 12345678 0
rd 0 00 12345678 0
rd 0 18 00000000 1
wr 1 3c 0000ffff 1
rm 0 04 0 0
en 0 0 1 0
pc 0 0 00000200 0
pl 0 020 0 0
xi 0 5 0 0
rd 0 00 00000200 0
rm 1 14 0 0
rt 0 0 0 0
pl 0 006 0 0
xi 0 1 0 0
ni 0 3 0 0
rt 0 0 0 0
xi 0 2 0 0
rt 0 0 0 0
pl 0 008 0 0
ni 0 4 0 0
wr 0 04 00000009 0
pl 0 001 0 0
xi 0 0 0 0
rt 0 0 0 0
pl 0 040 0 0
xi 0 6 0 0
pl 0 100 0 0
ni 0 3 0 0
pl 0 010 0 0
xi 0 4 0 0
rt 0 0 0 0
ni 0 2 0 0
rt 0 0 0 0
xi 0 8 0 0
rt 0 0 0 0
en 0 0 0 0
pl 0 080 0 0
ni 0 4 0 0
en 0 0 1 0
xi 0 7 0 0
rt 0 0 0 0
iw 0 0 1 0
pc 0 0 00000300 0
pl 0 200 0 0
ni 0 4 0 0
iw 0 0 0 0
xi 0 9 0 0
rd 1 00 00000300 0
rt 0 0 0 0
en 0 0 0 0
wr 1 0c 000000a0 0
rm 0 08 0 0
wr 0 10 00000028 0
rm 1 08 0 0
wr 1 08 00000004 0
rm 0 08 0 0
en 0 0 1 0
xi 0 2 0 0
rm 0 14 0 0
wr 0 14 00000000 0
rm 1 14 0 0
dw 0 04 00000011 00000022
rm 0 04 0 0
dw 0 04 00000044 00000088
rm 1 04 0 0

/* filelist.f */
source/pic_pkg.sv
source/apb_arbiter.sv
source/pic_regs.sv
source/pic_core.sv
source/pic_top.sv
sim/pic_props.sv
sim/tb_pic.sv

/* Bender.yml */
package:
  name: pic

sources:
  - target: any(rtl, simulation)
    files:
      - source/pic_pkg.sv
      - source/apb_arbiter.sv
      - source/pic_regs.sv
      - source/pic_core.sv
      - source/pic_top.sv
  - target: simulation
    files:
      - sim/pic_props.sv
      - sim/tb_pic.sv
